/* project.f */
+incdir+logic
logic/hazardPkg.sv
logic/bypass.sv
logic/stall.sv
logic/stagePipe.sv
logic/mulDivTimer.sv
logic/hazardUnit.sv
test/clockGen.sv
test/hazardUnitTb.sv

/* Makefile */
SOURCES := $(filter-out +%,$(shell cat project.f)) logic/hazard_macros.svh
BIN := obj_dir/VhazardUnitTb

.PHONY: all run clean

all: run

$(BIN): project.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal --top-module hazardUnitTb \
		--Mdir obj_dir -f project.f

run: $(BIN)
	./$(BIN) | tee sim.log
	grep -q "^Test completed successfully$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* test/hazardUnitTb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "hazard_macros.svh"

module hazardUnitTb;

	localparam int RANDOM_CYCLES = 400;
	localparam int MAX_CYCLES    = 2 * (RANDOM_CYCLES + 100);	// Twice the expected run

	localparam hazardPkg::instDesc EMPTY = '0;

	// Flag order {rfWr, dmRd, cp0Rd, bjOp, mulDiv, hiloRd}
	localparam logic [5:0] ALU    = 6'b100000;
	localparam logic [5:0] LOAD   = 6'b110000;
	localparam logic [5:0] BRANCH = 6'b000100;
	localparam logic [5:0] MULDIV = 6'b000010;
	localparam logic [5:0] MFHI   = 6'b100001;

	localparam hazardPkg::cacheStatus CACHE_OK = '{iDataOk: 1'b1, dDataOk: 1'b1,
		mem2DEn: 1'b0, mem1DEn: 1'b0, mem1AddrOk: 1'b1};
	localparam hazardPkg::cacheStatus WAIT_IDATA = '{iDataOk: 1'b0, dDataOk: 1'b1,
		mem2DEn: 1'b0, mem1DEn: 1'b0, mem1AddrOk: 1'b1};
	localparam hazardPkg::cacheStatus WAIT_DDATA = '{iDataOk: 1'b1, dDataOk: 1'b0,
		mem2DEn: 1'b1, mem1DEn: 1'b0, mem1AddrOk: 1'b1};
	localparam hazardPkg::cacheStatus WAIT_ADDR = '{iDataOk: 1'b1, dDataOk: 1'b1,
		mem2DEn: 1'b0, mem1DEn: 1'b1, mem1AddrOk: 1'b0};

	logic                  clk;
	logic                  rst_sign;
	hazardPkg::instDesc    idInst;
	hazardPkg::cacheStatus cache;
	logic                  mem1Ex;
	logic                  eretFlush;
	hazardPkg::pipeCtrl    ctrl;
	hazardPkg::fwdSel      fwdExRs;
	hazardPkg::fwdSel      fwdExRt;
	hazardPkg::fwdSel      fwdIdRs;
	hazardPkg::fwdSel      fwdIdRt;
	logic                  isStall;
	logic                  dcacheStall;

	// Reference copies of the stage registers
	hazardPkg::instDesc exM = '0;
	hazardPkg::instDesc mem1M = '0;
	hazardPkg::instDesc mem2M = '0;
	hazardPkg::instDesc wbM = '0;
	int                 mdCount = 0;	// Cycles left on multiply/divide
	logic [4*$bits(hazardPkg::instDesc)-1:0] frozen;
	logic               wasFrozen = 1'b0;
	logic               wasSquash = 1'b0;
	int                 errors = 0;
	int                 checks = 0;
	int                 cycles = 0;
	string              testName = "reset";
	logic [`PC_MSB:0]   pc = '0;

	clockGen clkGen (
		.clk      (clk),
		.rst_sign (rst_sign)
	);

	hazardUnit dut (
		.clk         (clk),
		.rst_sign    (rst_sign),
		.idInst      (idInst),
		.cache       (cache),
		.mem1Ex      (mem1Ex),
		.eretFlush   (eretFlush),
		.ctrl        (ctrl),
		.fwdExRs     (fwdExRs),
		.fwdExRt     (fwdExRt),
		.fwdIdRs     (fwdIdRs),
		.fwdIdRt     (fwdIdRt),
		.isStall     (isStall),
		.dcacheStall (dcacheStall)
	);

	task automatic checkValue(input string what, input logic [63:0] expected,
		input logic [63:0] actual);
		checks++;
		assert (expected == actual)
		else begin
			errors++;
			$display("[ERROR] %s %s: expected %0h, actual %0h", testName, what, expected, actual);
		end
	endtask

	task automatic checkTrue(input string what, input logic cond);
		checks++;
		assert (cond)
		else begin
			errors++;
			$display("%s: %s", testName, what);
		end
	endtask

	function automatic logic writes(input hazardPkg::instDesc d);
		return d.valid && d.rfWr && (d.dst != 0);
	endfunction

	function automatic logic feeds(input hazardPkg::instDesc d, input hazardPkg::instDesc id);
		return (d.dst == id.rs) || (d.dst == id.rt);
	endfunction

	function automatic logic slowResult(input hazardPkg::instDesc d);
		return d.valid && (d.dmRd || d.cp0Rd);	// Value known only in MEM2
	endfunction

	function automatic hazardPkg::fwdSel exSource(input logic [`REG_ADDR_MSB:0] r);
		if (writes(mem1M) && (mem1M.dst == r))
			return hazardPkg::FWD_MEM1;
		if (writes(mem2M) && (mem2M.dst == r))
			return hazardPkg::FWD_MEM2;
		if (writes(wbM) && (wbM.dst == r))
			return hazardPkg::FWD_WB;
		return hazardPkg::FWD_NONE;
	endfunction

	function automatic hazardPkg::fwdSel idSource(input logic [`REG_ADDR_MSB:0] r);
		if (!(idInst.valid && idInst.bjOp))
			return hazardPkg::FWD_NONE;
		if (writes(mem1M) && (mem1M.dst == r))
			return hazardPkg::FWD_MEM1;
		if (writes(mem2M) && (mem2M.dst == r))
			return hazardPkg::FWD_MEM2;
		return hazardPkg::FWD_NONE;
	endfunction

	function automatic logic cacheWaiting();
		return (cache.mem2DEn && !cache.dDataOk) || (cache.mem1DEn && !cache.mem1AddrOk)
			|| !cache.iDataOk;
	endfunction

	function automatic hazardPkg::pipeCtrl predictCtrl();
		hazardPkg::pipeCtrl c;
		logic loadHit;
		logic branchHit;
		logic hiloHit;
		loadHit = idInst.valid && ((slowResult(exM) && feeds(exM, idInst))
			|| (slowResult(mem1M) && feeds(mem1M, idInst)));
		branchHit = idInst.valid && idInst.bjOp
			&& ((writes(mem2M) && slowResult(mem2M) && feeds(mem2M, idInst))
			|| (writes(exM) && feeds(exM, idInst)));
		hiloHit = (mdCount != 0) && idInst.valid && idInst.hiloRd;
		c = '1;
		c.bubbleSel = 1'b0;
		c.squash = 1'b0;
		if (rst_sign) begin
			c.pcWr = 1'b0;
			c.ifIdWr = 1'b0;
			c.instSramEn = 1'b0;
			c.bubbleSel = 1'b1;	// EX fed bubbles while the front end is held
		end
		else if (mem1Ex || eretFlush)
			c.squash = 1'b1;
		else if (cacheWaiting())
			c = '0;
		else if (loadHit || branchHit || hiloHit) begin
			c.pcWr = 1'b0;
			c.ifIdWr = 1'b0;
			c.instSramEn = 1'b0;	// Fetch paused with PC
			c.bubbleSel = 1'b1;
		end
		return c;
	endfunction

	function automatic hazardPkg::instDesc makeInst(input int rs, input int rt, input int dst,
		input logic [5:0] flags);
		hazardPkg::instDesc d;
		d = EMPTY;
		d.valid = 1'b1;
		d.rs = `REG_ADDR_W'(rs);
		d.rt = `REG_ADDR_W'(rt);
		d.dst = `REG_ADDR_W'(dst);
		{d.rfWr, d.dmRd, d.cp0Rd, d.bjOp, d.mulDiv, d.hiloRd} = flags;
		return d;
	endfunction

	// Small register numbers so dependences show up often
	function automatic hazardPkg::instDesc randomInst();
		hazardPkg::instDesc d;
		d = EMPTY;
		d.valid = ($urandom_range(0, 7) != 0);
		d.pc = $urandom;
		d.rs = `REG_ADDR_W'($urandom_range(0, 3));
		d.rt = `REG_ADDR_W'($urandom_range(0, 3));
		d.dst = `REG_ADDR_W'($urandom_range(0, 3));
		d.rfWr = ($urandom_range(0, 3) != 0);
		d.dmRd = ($urandom_range(0, 3) == 0);
		d.cp0Rd = ($urandom_range(0, 15) == 0);
		d.bjOp = ($urandom_range(0, 5) == 0);
		d.mulDiv = ($urandom_range(0, 9) == 0);
		d.hiloRd = ($urandom_range(0, 5) == 0);
		return d;
	endfunction

	function automatic hazardPkg::cacheStatus randomCache();
		hazardPkg::cacheStatus c;
		c = CACHE_OK;
		if ($urandom_range(0, 7) == 0) begin
			c.iDataOk = ($urandom_range(0, 2) != 0);
			c.mem2DEn = 1'($urandom_range(0, 1));
			c.dDataOk = 1'($urandom_range(0, 1));
			c.mem1DEn = 1'($urandom_range(0, 1));
			c.mem1AddrOk = 1'($urandom_range(0, 1));
		end
		return c;
	endfunction

	// Present one ID instruction and keep it there while the pipe stalls
	task automatic issue(input hazardPkg::instDesc d, output int stalls);
		stalls = 0;
		d.pc = pc;
		pc = pc + 4;
		@(posedge clk);
		idInst <= d;
		@(negedge clk);
		while (isStall) begin
			stalls++;
			@(negedge clk);
		end
	endtask

	task automatic holdCache(input hazardPkg::cacheStatus c, input int n);
		@(posedge clk);
		cache <= c;
		repeat (n) @(posedge clk);
		cache <= CACHE_OK;
	endtask

	// Outputs are checked mid-cycle, then the model takes the coming edge
	always @(negedge clk) begin
		hazardPkg::pipeCtrl want;
		want = predictCtrl();
		checkValue("ctrl", 64'(want), 64'(ctrl));
		checkValue("isStall", 64'(!want.pcWr), 64'(isStall));
		checkValue("dcacheStall", 64'(cacheWaiting()), 64'(dcacheStall));
		checkValue("fwdExRs", 64'(exSource(exM.rs)), 64'(fwdExRs));
		checkValue("fwdExRt", 64'(exSource(exM.rt)), 64'(fwdExRt));
		checkValue("fwdIdRs", 64'(idSource(idInst.rs)), 64'(fwdIdRs));
		checkValue("fwdIdRt", 64'(idSource(idInst.rt)), 64'(fwdIdRt));
		checkTrue("register 0 was forwarded to EX",
			((exM.rs != 0) || (fwdExRs == hazardPkg::FWD_NONE))
			&& ((exM.rt != 0) || (fwdExRt == hazardPkg::FWD_NONE)));
		checkTrue("branch compare forwarded from WB",
			(fwdIdRs != hazardPkg::FWD_WB) && (fwdIdRt != hazardPkg::FWD_WB));
		if (wasSquash)
			checkTrue("an instruction survived the flush in EX, MEM1 or MEM2",
				!(dut.exInst.valid || dut.mem1Inst.valid || dut.mem2Inst.valid));
		if (wasFrozen)
			checkTrue("stage registers moved during a cache wait",
				frozen == {dut.exInst, dut.mem1Inst, dut.mem2Inst, dut.wbInst});
		wasSquash = !rst_sign && want.squash;
		wasFrozen = !rst_sign && cacheWaiting() && !want.squash;
		frozen = {dut.exInst, dut.mem1Inst, dut.mem2Inst, dut.wbInst};
		if (rst_sign) begin
			exM = EMPTY;
			mem1M = EMPTY;
			mem2M = EMPTY;
			wbM = EMPTY;
			mdCount = 0;
		end
		else begin
			if (exM.valid && exM.mulDiv && ctrl.exMem1Wr)
				mdCount = `MULDIV_CYCLES;
			else if (mdCount != 0)
				mdCount--;
			if (ctrl.mem2WbWr)
				wbM = mem2M;	// Oldest first
			if (ctrl.mem1Mem2Wr)
				mem2M = ctrl.squash ? EMPTY : mem1M;
			if (ctrl.exMem1Wr)
				mem1M = ctrl.squash ? EMPTY : exM;
			if (ctrl.idExWr)
				exM = (ctrl.bubbleSel || ctrl.squash) ? EMPTY : idInst;
		end
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: run did not end within %0d cycles (checks: %0d, errors: %0d)",
				MAX_CYCLES, checks, errors);
			$display("Test failed");
			$finish;
		end
	end

	initial begin
		int stalls;
		logic hold;
		void'($urandom(32'h57bf38ff));
		idInst = EMPTY;
		cache = CACHE_OK;
		mem1Ex = 1'b0;
		eretFlush = 1'b0;
		@(negedge clk);
		while (rst_sign) @(negedge clk);

		testName = "forward";
		issue(makeInst(0, 0, 1, ALU), stalls);
		issue(makeInst(0, 0, 2, ALU), stalls);
		issue(makeInst(1, 2, 3, ALU), stalls);
		issue(makeInst(3, 1, 0, ALU), stalls);	// Writes r0
		issue(makeInst(0, 3, 1, ALU), stalls);

		testName = "branch";
		issue(makeInst(1, 0, 0, BRANCH), stalls);	// Producer still in EX
		issue(makeInst(0, 0, 2, LOAD), stalls);
		issue(makeInst(2, 1, 0, BRANCH), stalls);
		checkValue("load to branch stall cycles", 3, stalls);

		testName = "loadUse";
		issue(makeInst(0, 0, 3, LOAD), stalls);
		issue(makeInst(3, 0, 1, ALU), stalls);
		checkValue("stall cycles", 2, stalls);
		@(posedge clk);
		idInst <= EMPTY;
		@(negedge clk);
		checkValue("fwdExRs after load", 64'(hazardPkg::FWD_WB), 64'(fwdExRs));	// Load now in WB

		testName = "cacheWait";
		holdCache(WAIT_IDATA, 2);
		holdCache(WAIT_DDATA, 2);
		holdCache(WAIT_ADDR, 2);
		issue(makeInst(0, 0, 2, LOAD), stalls);
		@(posedge clk);
		idInst <= makeInst(2, 2, 1, ALU);
		holdCache(WAIT_DDATA, 3);	// Lands on top of the load-use stall
		@(negedge clk);
		while (isStall) @(negedge clk);

		testName = "flush";
		issue(makeInst(0, 0, 1, LOAD), stalls);
		@(posedge clk);
		idInst <= makeInst(1, 0, 2, ALU);
		@(posedge clk);
		mem1Ex <= 1'b1;
		@(posedge clk);
		mem1Ex <= 1'b0;
		eretFlush <= 1'b1;
		@(posedge clk);
		eretFlush <= 1'b0;
		idInst <= EMPTY;

		testName = "mulDiv";
		issue(makeInst(1, 2, 0, MULDIV), stalls);
		issue(EMPTY, stalls);
		issue(makeInst(0, 0, 3, MFHI), stalls);
		checkValue("HI/LO stall cycles", `MULDIV_CYCLES, stalls);

		testName = "random";
		hold = 1'b0;
		repeat (RANDOM_CYCLES) begin
			@(posedge clk);
			if (!hold)
				idInst <= randomInst();
			cache <= randomCache();
			mem1Ex <= ($urandom_range(0, 31) == 0);
			eretFlush <= ($urandom_range(0, 31) == 0);
			@(negedge clk);
			hold = isStall;
		end
		@(posedge clk);
		idInst <= EMPTY;
		cache <= CACHE_OK;
		mem1Ex <= 1'b0;
		eretFlush <= 1'b0;
		repeat (2) @(posedge clk);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* test/clockGen.sv */
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
	parameter int PERIOD       = 40,
	parameter int RESET_CYCLES = 2
) (
	output logic clk,
	output logic rst_sign
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// Held over the first rising edges
	initial begin
		rst_sign = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_sign <= 1'b0;
	end

endmodule

`default_nettype wire

/* logic/hazardUnit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "hazard_macros.svh"

module hazardUnit (
	input  logic                  clk,
	input  logic                  rst_sign,
	input  hazardPkg::instDesc    idInst,
	input  hazardPkg::cacheStatus cache,
	input  logic                  mem1Ex,	// Exception raised in MEM1
	input  logic                  eretFlush,
	output hazardPkg::pipeCtrl    ctrl,
	output hazardPkg::fwdSel      fwdExRs,
	output hazardPkg::fwdSel      fwdExRt,
	output hazardPkg::fwdSel      fwdIdRs,
	output hazardPkg::fwdSel      fwdIdRt,
	output logic                  isStall,
	output logic                  dcacheStall
);

	hazardPkg::instDesc exInst;
	hazardPkg::instDesc mem1Inst;
	hazardPkg::instDesc mem2Inst;
	hazardPkg::instDesc wbInst;
	logic               busy;	// Multiply/divide in flight

	stagePipe uPipe (
		.clk      (clk),
		.rst_sign (rst_sign),
		.idInst   (idInst),
		.ctrl     (ctrl),
		.exInst   (exInst),
		.mem1Inst (mem1Inst),
		.mem2Inst (mem2Inst),
		.wbInst   (wbInst)
	);

	mulDivTimer #(
		.LATENCY (`MULDIV_CYCLES)
	) uTimer (
		.clk      (clk),
		.rst_sign (rst_sign),
		.exInst   (exInst),
		.exMem1Wr (ctrl.exMem1Wr),
		.busy     (busy)
	);

	bypass uBypass (
		.exInst   (exInst),
		.mem1Inst (mem1Inst),
		.mem2Inst (mem2Inst),
		.wbInst   (wbInst),
		.idInst   (idInst),
		.fwdExRs  (fwdExRs),
		.fwdExRt  (fwdExRt),
		.fwdIdRs  (fwdIdRs),
		.fwdIdRt  (fwdIdRt)
	);

	stall uStall (
		.rst_sign    (rst_sign),
		.idInst      (idInst),
		.exInst      (exInst),
		.mem1Inst    (mem1Inst),
		.mem2Inst    (mem2Inst),
		.cache       (cache),
		.mem1Ex      (mem1Ex),
		.eretFlush   (eretFlush),
		.busy        (busy),
		.ctrl        (ctrl),
		.dcacheStall (dcacheStall),
		.isStall     (isStall)
	);

endmodule

`default_nettype wire

/* logic/mulDivTimer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "hazard_macros.svh"

module mulDivTimer #(
	parameter int LATENCY = `MULDIV_CYCLES
) (
	input  logic               clk,
	input  logic               rst_sign,
	input  hazardPkg::instDesc exInst,
	input  logic               exMem1Wr,
	output logic               busy
);

	localparam int CNT_W = $clog2(LATENCY + 1);

	logic [CNT_W-1:0] count;
	logic             start;

	// Issue happens as the instruction moves on to MEM1
	assign start = exInst.valid && exInst.mulDiv && exMem1Wr;

	always_ff @(posedge clk) begin
		if (rst_sign) begin
			count <= '0;
		end
		else if (start) begin
			count <= CNT_W'(LATENCY);
		end
		else if (count != '0) begin
			count <= count - 1'b1;	// Keeps running through freezes
		end
	end

	assign busy = (count != '0);

endmodule

`default_nettype wire

/* logic/stagePipe.sv */
`timescale 1ns/1ps
`default_nettype none

module stagePipe (
	input  logic               clk,
	input  logic               rst_sign,
	input  hazardPkg::instDesc idInst,
	input  hazardPkg::pipeCtrl ctrl,
	output hazardPkg::instDesc exInst,
	output hazardPkg::instDesc mem1Inst,
	output hazardPkg::instDesc mem2Inst,
	output hazardPkg::instDesc wbInst
);

	localparam hazardPkg::instDesc BUBBLE = '0;

	hazardPkg::instDesc exNext;
	hazardPkg::instDesc mem1Next;
	hazardPkg::instDesc mem2Next;

	// Bubble insertion on the way into each stage
	assign exNext   = (ctrl.bubbleSel || ctrl.squash) ? BUBBLE : idInst;
	assign mem1Next = ctrl.squash ? BUBBLE : exInst;
	assign mem2Next = ctrl.squash ? BUBBLE : mem1Inst;

	always_ff @(posedge clk) begin
		if (rst_sign) begin
			exInst.valid <= 1'b0;
		end
		else if (ctrl.idExWr) begin
			exInst <= exNext;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_sign) begin
			mem1Inst.valid <= 1'b0;
		end
		else if (ctrl.exMem1Wr) begin
			mem1Inst <= mem1Next;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_sign) begin
			mem2Inst.valid <= 1'b0;
		end
		else if (ctrl.mem1Mem2Wr) begin
			mem2Inst <= mem2Next;
		end
	end

	// WB is never squashed, it already committed
	always_ff @(posedge clk) begin
		if (rst_sign) begin
			wbInst.valid <= 1'b0;
		end
		else if (ctrl.mem2WbWr) begin
			wbInst <= mem2Inst;
		end
	end

endmodule

`default_nettype wire

/* logic/stall.sv */
`timescale 1ns/1ps
`default_nettype none

module stall (
	input  logic                  rst_sign,
	input  hazardPkg::instDesc    idInst,
	input  hazardPkg::instDesc    exInst,
	input  hazardPkg::instDesc    mem1Inst,
	input  hazardPkg::instDesc    mem2Inst,
	input  hazardPkg::cacheStatus cache,
	input  logic                  mem1Ex,
	input  logic                  eretFlush,
	input  logic                  busy,
	output hazardPkg::pipeCtrl    ctrl,
	output logic                  dcacheStall,
	output logic                  isStall
);

	// Front end held, rest of the pipe drains
	localparam hazardPkg::pipeCtrl CTRL_RESET = '{
		pcWr: 1'b0, ifIdWr: 1'b0, idExWr: 1'b1, exMem1Wr: 1'b1,
		mem1Mem2Wr: 1'b1, mem2WbWr: 1'b1, instSramEn: 1'b0,
		bubbleSel: 1'b1, squash: 1'b0
	};
	localparam hazardPkg::pipeCtrl CTRL_FLUSH = '{
		pcWr: 1'b1, ifIdWr: 1'b1, idExWr: 1'b1, exMem1Wr: 1'b1,
		mem1Mem2Wr: 1'b1, mem2WbWr: 1'b1, instSramEn: 1'b1,
		bubbleSel: 1'b0, squash: 1'b1
	};
	localparam hazardPkg::pipeCtrl CTRL_FREEZE = '{
		pcWr: 1'b0, ifIdWr: 1'b0, idExWr: 1'b0, exMem1Wr: 1'b0,
		mem1Mem2Wr: 1'b0, mem2WbWr: 1'b0, instSramEn: 1'b0,
		bubbleSel: 1'b0, squash: 1'b0
	};
	// Stall ID, bubble into EX
	localparam hazardPkg::pipeCtrl CTRL_HOLD = '{
		pcWr: 1'b0, ifIdWr: 1'b0, idExWr: 1'b1, exMem1Wr: 1'b1,
		mem1Mem2Wr: 1'b1, mem2WbWr: 1'b1, instSramEn: 1'b0,
		bubbleSel: 1'b1, squash: 1'b0
	};
	localparam hazardPkg::pipeCtrl CTRL_RUN = '{
		pcWr: 1'b1, ifIdWr: 1'b1, idExWr: 1'b1, exMem1Wr: 1'b1,
		mem1Mem2Wr: 1'b1, mem2WbWr: 1'b1, instSramEn: 1'b1,
		bubbleSel: 1'b0, squash: 1'b0
	};

	// Load or cp0 read, result not ready before MEM2
	function automatic logic lateResult(input hazardPkg::instDesc d);
		return d.valid && (d.dmRd || d.cp0Rd);
	endfunction

	function automatic logic hitsId(
		input hazardPkg::instDesc d,
		input hazardPkg::instDesc id
	);
		return (d.dst == id.rs) || (d.dst == id.rt);
	endfunction

	logic flush;
	logic idBranch;
	logic hiloWait;
	logic loadUse;
	logic branchMem2;
	logic branchEx;

	assign dcacheStall = (cache.mem2DEn & ~cache.dDataOk)	// Data not back
		| (cache.mem1DEn & ~cache.mem1AddrOk)	// Address not taken
		| ~cache.iDataOk;

	assign flush    = mem1Ex | eretFlush;
	assign idBranch = idInst.valid && idInst.bjOp;
	assign hiloWait = busy && idInst.valid && idInst.hiloRd;

	assign loadUse = idInst.valid
		&& ((lateResult(exInst) && hitsId(exInst, idInst))
		|| (lateResult(mem1Inst) && hitsId(mem1Inst, idInst)));

	assign branchMem2 = idBranch && hazardPkg::isWriter(mem2Inst)
		&& lateResult(mem2Inst) && hitsId(mem2Inst, idInst);

	assign branchEx = idBranch && hazardPkg::isWriter(exInst) && hitsId(exInst, idInst);

	always_comb begin
		if (rst_sign)
			ctrl = CTRL_RESET;
		else if (flush)
			ctrl = CTRL_FLUSH;	// Overrides any pending stall
		else if (dcacheStall)
			ctrl = CTRL_FREEZE;
		else if (hiloWait || loadUse || branchMem2 || branchEx)
			ctrl = CTRL_HOLD;
		else
			ctrl = CTRL_RUN;
	end

	assign isStall = ~ctrl.pcWr;

endmodule

`default_nettype wire

/* logic/bypass.sv */
`timescale 1ns/1ps
`default_nettype none
`include "hazard_macros.svh"

module bypass (
	input  hazardPkg::instDesc exInst,
	input  hazardPkg::instDesc mem1Inst,
	input  hazardPkg::instDesc mem2Inst,
	input  hazardPkg::instDesc wbInst,
	input  hazardPkg::instDesc idInst,
	output hazardPkg::fwdSel   fwdExRs,
	output hazardPkg::fwdSel   fwdExRt,
	output hazardPkg::fwdSel   fwdIdRs,
	output hazardPkg::fwdSel   fwdIdRt
);

	// Youngest matching writer wins
	function automatic hazardPkg::fwdSel exPick(
		input logic [`REG_ADDR_MSB:0] src,
		input hazardPkg::instDesc m1,
		input hazardPkg::instDesc m2,
		input hazardPkg::instDesc wb
	);
		if (hazardPkg::isWriter(m1) && (m1.dst == src))
			return hazardPkg::FWD_MEM1;
		else if (hazardPkg::isWriter(m2) && (m2.dst == src))
			return hazardPkg::FWD_MEM2;
		else if (hazardPkg::isWriter(wb) && (wb.dst == src))
			return hazardPkg::FWD_WB;
		else
			return hazardPkg::FWD_NONE;
	endfunction

	// Branch compare only sees MEM1 and MEM2
	function automatic hazardPkg::fwdSel idPick(
		input logic [`REG_ADDR_MSB:0] src,
		input logic isBranch,
		input hazardPkg::instDesc m1,
		input hazardPkg::instDesc m2
	);
		if (!isBranch)
			return hazardPkg::FWD_NONE;
		else if (hazardPkg::isWriter(m1) && (m1.dst == src))
			return hazardPkg::FWD_MEM1;
		else if (hazardPkg::isWriter(m2) && (m2.dst == src))
			return hazardPkg::FWD_MEM2;
		else
			return hazardPkg::FWD_NONE;
	endfunction

	logic idBranch;

	assign idBranch = idInst.valid && idInst.bjOp;

	always_comb begin
		fwdExRs = exPick(exInst.rs, mem1Inst, mem2Inst, wbInst);
		fwdExRt = exPick(exInst.rt, mem1Inst, mem2Inst, wbInst);
		fwdIdRs = idPick(idInst.rs, idBranch, mem1Inst, mem2Inst);	// Branch rs
		fwdIdRt = idPick(idInst.rt, idBranch, mem1Inst, mem2Inst);	// Branch rt
	end

endmodule

`default_nettype wire

/* logic/hazardPkg.sv */
`default_nettype none
`include "hazard_macros.svh"

package hazardPkg;

	// One pipeline slot as seen by the hazard logic
	typedef struct packed {
		logic                   valid;	// Slot holds a real instruction
		logic [`PC_MSB:0]       pc;
		logic [`REG_ADDR_MSB:0] rs;
		logic [`REG_ADDR_MSB:0] rt;
		logic [`REG_ADDR_MSB:0] dst;	// Register written back
		logic                   rfWr;	// Writes register file
		logic                   dmRd;	// Data load
		logic                   cp0Rd;	// Coprocessor 0 read
		logic                   bjOp;	// Branch compared in ID
		logic                   mulDiv;	// Starts multiply or divide
		logic                   hiloRd;	// Reads HI or LO
	} instDesc;

	typedef enum logic [1:0] {
		FWD_NONE = 2'b00,	// Register file value
		FWD_MEM1 = 2'b01,
		FWD_MEM2 = 2'b10,
		FWD_WB   = 2'b11
	} fwdSel;

	typedef struct packed {
		logic pcWr;
		logic ifIdWr;
		logic idExWr;
		logic exMem1Wr;
		logic mem1Mem2Wr;
		logic mem2WbWr;
		logic instSramEn;
		logic bubbleSel;	// EX takes a bubble instead of ID
		logic squash;	// EX, MEM1, MEM2 take bubbles
	} pipeCtrl;

	typedef struct packed {
		logic iDataOk;
		logic dDataOk;
		logic mem2DEn;	// MEM2 access waiting for data
		logic mem1DEn;	// MEM1 access requesting
		logic mem1AddrOk;	// Address taken or uncached
	} cacheStatus;

	// A stage whose result can be forwarded
	function automatic logic isWriter(input instDesc d);
		return d.valid && d.rfWr && (d.dst != '0);
	endfunction

endpackage

`default_nettype wire

/* logic/hazard_macros.svh */
`ifndef HAZARD_MACROS_SVH
`define HAZARD_MACROS_SVH

// Register file address width
`define REG_ADDR_W 5

// Program counter width
`define PC_W 32

// Cycles the multiply/divide unit stays busy after issue
`define MULDIV_CYCLES 4

// Widths derived from the above
`define REG_ADDR_MSB (`REG_ADDR_W - 1)
`define PC_MSB (`PC_W - 1)

`endif
